// File: hdl/insn_decoder.sv
// #########################################################################
// Combinational RV32I decoder. Any word whose low bits are not 11 decodes
// as invalid, as do reserved load and store sizes.
// #########################################################################
`timescale 1ns/1ps

module insn_decoder (
  input  trace_pkg::word_t        insn,
  output trace_pkg::insn_class_t  insn_class,
  output trace_pkg::op_t          op,
  output trace_pkg::access_mask_t access
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // Every major opcode ends in 11, so compressed words fall through to invalid
  always_comb begin
    op = trace_pkg::OP_INVALID;
    case (opcode)
      trace_pkg::OPC_LUI:   op = trace_pkg::OP_LUI;
      trace_pkg::OPC_AUIPC: op = trace_pkg::OP_AUIPC;
      trace_pkg::OPC_JAL:   op = trace_pkg::OP_JAL;
      trace_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) begin
          op = trace_pkg::OP_JALR;
        end
      end
      trace_pkg::OPC_BRANCH: begin
        case (funct3)
          3'b000: op = trace_pkg::OP_BEQ;
          3'b001: op = trace_pkg::OP_BNE;
          3'b100: op = trace_pkg::OP_BLT;
          3'b101: op = trace_pkg::OP_BGE;
          3'b110: op = trace_pkg::OP_BLTU;
          3'b111: op = trace_pkg::OP_BGEU;
          default: op = trace_pkg::OP_INVALID;
        endcase
      end
      trace_pkg::OPC_LOAD: begin
        case (funct3)
          3'b000: op = trace_pkg::OP_LB;
          3'b001: op = trace_pkg::OP_LH;
          3'b010: op = trace_pkg::OP_LW;
          3'b100: op = trace_pkg::OP_LBU;
          3'b101: op = trace_pkg::OP_LHU;
          default: op = trace_pkg::OP_INVALID;
        endcase
      end
      trace_pkg::OPC_STORE: begin
        case (funct3)
          3'b000: op = trace_pkg::OP_SB;
          3'b001: op = trace_pkg::OP_SH;
          3'b010: op = trace_pkg::OP_SW;
          default: op = trace_pkg::OP_INVALID;
        endcase
      end
      trace_pkg::OPC_OPIMM: begin
        case (funct3)
          3'b000: op = trace_pkg::OP_ADDI;
          3'b010: op = trace_pkg::OP_SLTI;
          3'b011: op = trace_pkg::OP_SLTIU;
          3'b100: op = trace_pkg::OP_XORI;
          3'b110: op = trace_pkg::OP_ORI;
          3'b111: op = trace_pkg::OP_ANDI;
          // Shifts carry funct7 in the upper immediate bits
          3'b001: op = (funct7 == 7'b0000000) ? trace_pkg::OP_SLLI : trace_pkg::OP_INVALID;
          default: begin
            if (funct7 == 7'b0000000) begin
              op = trace_pkg::OP_SRLI;
            end else if (funct7 == 7'b0100000) begin
              op = trace_pkg::OP_SRAI;
            end
          end
        endcase
      end
      trace_pkg::OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: op = trace_pkg::OP_ADD;
            3'b001: op = trace_pkg::OP_SLL;
            3'b010: op = trace_pkg::OP_SLT;
            3'b011: op = trace_pkg::OP_SLTU;
            3'b100: op = trace_pkg::OP_XOR;
            3'b101: op = trace_pkg::OP_SRL;
            3'b110: op = trace_pkg::OP_OR;
            default: op = trace_pkg::OP_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = trace_pkg::OP_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          op = trace_pkg::OP_SRA;
        end
      end
      trace_pkg::OPC_MISC_MEM: begin
        if (funct3 == 3'b000) begin
          op = trace_pkg::OP_FENCE;
        end else if (funct3 == 3'b001) begin
          op = trace_pkg::OP_FENCE_I;
        end
      end
      trace_pkg::OPC_SYSTEM: begin
        case (funct3)
          // Privileged instructions match only their full encoding
          3'b000: begin
            case (insn)
              32'h0000_0073: op = trace_pkg::OP_ECALL;
              32'h0010_0073: op = trace_pkg::OP_EBREAK;
              32'h3020_0073: op = trace_pkg::OP_MRET;
              32'h7b20_0073: op = trace_pkg::OP_DRET;
              32'h1050_0073: op = trace_pkg::OP_WFI;
              default: op = trace_pkg::OP_INVALID;
            endcase
          end
          3'b001: op = trace_pkg::OP_CSRRW;
          3'b010: op = trace_pkg::OP_CSRRS;
          3'b011: op = trace_pkg::OP_CSRRC;
          3'b101: op = trace_pkg::OP_CSRRWI;
          3'b110: op = trace_pkg::OP_CSRRSI;
          3'b111: op = trace_pkg::OP_CSRRCI;
          default: op = trace_pkg::OP_INVALID;
        endcase
      end
      default: op = trace_pkg::OP_INVALID;
    endcase
  end

  // Format class follows from the mnemonic
  always_comb begin
    if (op inside {trace_pkg::OP_LUI, trace_pkg::OP_AUIPC}) begin
      insn_class = trace_pkg::CLASS_U;
    end else if (op == trace_pkg::OP_JAL) begin
      insn_class = trace_pkg::CLASS_J;
    end else if (op == trace_pkg::OP_JALR) begin
      insn_class = trace_pkg::CLASS_JALR;
    end else if (op >= trace_pkg::OP_BEQ && op <= trace_pkg::OP_BGEU) begin
      insn_class = trace_pkg::CLASS_B;
    end else if (op >= trace_pkg::OP_LB && op <= trace_pkg::OP_LHU) begin
      insn_class = trace_pkg::CLASS_LOAD;
    end else if (op >= trace_pkg::OP_SB && op <= trace_pkg::OP_SW) begin
      insn_class = trace_pkg::CLASS_STORE;
    end else if (op >= trace_pkg::OP_ADDI && op <= trace_pkg::OP_ANDI) begin
      insn_class = trace_pkg::CLASS_I;
    end else if (op >= trace_pkg::OP_SLLI && op <= trace_pkg::OP_SRAI) begin
      insn_class = trace_pkg::CLASS_SHIFT;
    end else if (op >= trace_pkg::OP_ADD && op <= trace_pkg::OP_AND) begin
      insn_class = trace_pkg::CLASS_R;
    end else if (op inside {trace_pkg::OP_FENCE, trace_pkg::OP_FENCE_I}) begin
      insn_class = trace_pkg::CLASS_FENCE;
    end else if (op >= trace_pkg::OP_CSRRW && op <= trace_pkg::OP_CSRRC) begin
      insn_class = trace_pkg::CLASS_CSR;
    end else if (op >= trace_pkg::OP_CSRRWI && op <= trace_pkg::OP_CSRRCI) begin
      insn_class = trace_pkg::CLASS_CSR_IMM;
    end else if (op >= trace_pkg::OP_ECALL && op <= trace_pkg::OP_WFI) begin
      insn_class = trace_pkg::CLASS_SYS;
    end else begin
      insn_class = trace_pkg::CLASS_INVALID;
    end
  end

  // Branches read both sources but write no rd
  always_comb begin
    access[trace_pkg::ACC_RS1] = insn_class inside {trace_pkg::CLASS_R, trace_pkg::CLASS_I,
        trace_pkg::CLASS_SHIFT, trace_pkg::CLASS_JALR, trace_pkg::CLASS_B,
        trace_pkg::CLASS_LOAD, trace_pkg::CLASS_STORE, trace_pkg::CLASS_CSR};
    access[trace_pkg::ACC_RS2] = insn_class inside {trace_pkg::CLASS_R, trace_pkg::CLASS_B,
        trace_pkg::CLASS_STORE};
    access[trace_pkg::ACC_RD] = insn_class inside {trace_pkg::CLASS_R, trace_pkg::CLASS_I,
        trace_pkg::CLASS_SHIFT, trace_pkg::CLASS_JALR, trace_pkg::CLASS_U, trace_pkg::CLASS_J,
        trace_pkg::CLASS_LOAD, trace_pkg::CLASS_CSR, trace_pkg::CLASS_CSR_IMM};
    access[trace_pkg::ACC_MEM] = insn_class inside {trace_pkg::CLASS_LOAD,
        trace_pkg::CLASS_STORE};
  end

endmodule

// File: hdl/operand_calc.sv
// #########################################################################
// Immediate, target and memory data selection. Purely combinational.
// The U immediate is reported unshifted, as the raw 20-bit field.
// #########################################################################
`timescale 1ns/1ps

module operand_calc (
  input  trace_pkg::word_t       insn,
  input  trace_pkg::word_t       pc,
  input  trace_pkg::word_t       pc_next,
  input  trace_pkg::insn_class_t insn_class,
  input  trace_pkg::mem_mask_t   mem_rmask,
  input  trace_pkg::word_t       mem_rdata,
  input  trace_pkg::word_t       mem_wdata,
  output trace_pkg::word_t       imm,
  output trace_pkg::word_t       target,
  output trace_pkg::word_t       mem_data
);

  trace_pkg::word_t imm_i;
  trace_pkg::word_t imm_s;
  trace_pkg::word_t imm_b;

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  // B offset is in multiples of two bytes
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    case (insn_class)
      trace_pkg::CLASS_I,
      trace_pkg::CLASS_JALR,
      trace_pkg::CLASS_LOAD:    imm = imm_i;
      trace_pkg::CLASS_SHIFT:   imm = {27'b0, insn[24:20]};
      trace_pkg::CLASS_STORE:   imm = imm_s;
      trace_pkg::CLASS_B:       imm = imm_b;
      trace_pkg::CLASS_U:       imm = {12'b0, insn[31:12]};
      // CSR address, reported as a number
      trace_pkg::CLASS_CSR,
      trace_pkg::CLASS_CSR_IMM: imm = {20'b0, insn[31:20]};
      // Predecessor and successor sets
      trace_pkg::CLASS_FENCE:   imm = {24'b0, insn[27:20]};
      default:                  imm = '0;
    endcase
  end

  // Jumps take the retired next PC, branches need the computed target
  always_comb begin
    case (insn_class)
      trace_pkg::CLASS_B:    target = pc + imm_b;
      trace_pkg::CLASS_J,
      trace_pkg::CLASS_JALR: target = pc_next;
      default:               target = '0;
    endcase
  end

  assign mem_data = (mem_rmask != '0) ? mem_rdata : mem_wdata;

endmodule

// File: hdl/rvfi_trace_top.sv
// #########################################################################
// RVFI retirement trace recorder. Inputs are sampled only when rvfi_valid
// is high; the record follows one cycle later with a rec_valid pulse.
// The memory data field follows rmask only, rvfi_mem_wmask is not used.
// #########################################################################
`timescale 1ns/1ps

module rvfi_trace_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rvfi_valid,
  input  trace_pkg::word_t        rvfi_insn,
  input  trace_pkg::word_t        rvfi_pc_rdata,
  input  trace_pkg::word_t        rvfi_pc_wdata,
  input  trace_pkg::reg_addr_t    rvfi_rs1_addr,
  input  trace_pkg::reg_addr_t    rvfi_rs2_addr,
  input  trace_pkg::reg_addr_t    rvfi_rd_addr,
  input  trace_pkg::word_t        rvfi_rs1_rdata,
  input  trace_pkg::word_t        rvfi_rs2_rdata,
  input  trace_pkg::word_t        rvfi_rd_wdata,
  input  trace_pkg::word_t        rvfi_mem_addr,
  input  trace_pkg::mem_mask_t    rvfi_mem_rmask,
  input  trace_pkg::mem_mask_t    rvfi_mem_wmask,
  input  trace_pkg::word_t        rvfi_mem_rdata,
  input  trace_pkg::word_t        rvfi_mem_wdata,
  output logic                    rec_valid,
  output trace_pkg::cycle_t       rec_cycle,
  output trace_pkg::word_t        rec_insn,
  output trace_pkg::word_t        rec_pc,
  output trace_pkg::word_t        rec_imm,
  output trace_pkg::word_t        rec_target,
  output trace_pkg::word_t        rec_mem_addr,
  output trace_pkg::word_t        rec_mem_data,
  output trace_pkg::word_t        rec_rs1_data,
  output trace_pkg::word_t        rec_rs2_data,
  output trace_pkg::word_t        rec_rd_data,
  output trace_pkg::reg_addr_t    rec_rs1,
  output trace_pkg::reg_addr_t    rec_rs2,
  output trace_pkg::reg_addr_t    rec_rd,
  output trace_pkg::insn_class_t  rec_insn_class,
  output trace_pkg::op_t          rec_op,
  output trace_pkg::access_mask_t rec_access
);

  trace_pkg::insn_class_t  insn_class;
  trace_pkg::op_t          op;
  trace_pkg::access_mask_t access;
  trace_pkg::word_t        imm;
  trace_pkg::word_t        target;
  trace_pkg::word_t        mem_data;

  insn_decoder decoder_i (
    .insn       (rvfi_insn),
    .insn_class (insn_class),
    .op         (op),
    .access     (access)
  );

  operand_calc calc_i (
    .insn       (rvfi_insn),
    .pc         (rvfi_pc_rdata),
    .pc_next    (rvfi_pc_wdata),
    .insn_class (insn_class),
    .mem_rmask  (rvfi_mem_rmask),
    .mem_rdata  (rvfi_mem_rdata),
    .mem_wdata  (rvfi_mem_wdata),
    .imm        (imm),
    .target     (target),
    .mem_data   (mem_data)
  );

  trace_record_reg record_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid          (rvfi_valid),
    .insn           (rvfi_insn),
    .pc             (rvfi_pc_rdata),
    .imm            (imm),
    .target         (target),
    .mem_addr       (rvfi_mem_addr),
    .mem_data       (mem_data),
    .rs1_data       (rvfi_rs1_rdata),
    .rs2_data       (rvfi_rs2_rdata),
    .rd_data        (rvfi_rd_wdata),
    .rs1            (rvfi_rs1_addr),
    .rs2            (rvfi_rs2_addr),
    .rd             (rvfi_rd_addr),
    .insn_class     (insn_class),
    .op             (op),
    .access         (access),
    .rec_valid      (rec_valid),
    .rec_cycle      (rec_cycle),
    .rec_insn       (rec_insn),
    .rec_pc         (rec_pc),
    .rec_imm        (rec_imm),
    .rec_target     (rec_target),
    .rec_mem_addr   (rec_mem_addr),
    .rec_mem_data   (rec_mem_data),
    .rec_rs1_data   (rec_rs1_data),
    .rec_rs2_data   (rec_rs2_data),
    .rec_rd_data    (rec_rd_data),
    .rec_rs1        (rec_rs1),
    .rec_rs2        (rec_rs2),
    .rec_rd         (rec_rd),
    .rec_insn_class (rec_insn_class),
    .rec_op         (rec_op),
    .rec_access     (rec_access)
  );

endmodule

// File: hdl/trace_pkg.sv
// #########################################################################
// Shared types and codes for the RVFI trace recorder. RV32I base set only,
// so compressed, M and B encodings have no mnemonic code here.
// #########################################################################

package trace_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] cycle_t;
  typedef logic [3:0]  mem_mask_t;
  typedef logic [3:0]  insn_class_t;
  typedef logic [5:0]  op_t;
  typedef logic [3:0]  access_mask_t;

  // Bit positions in access_mask_t
  localparam int ACC_RS1 = 0;
  localparam int ACC_RS2 = 1;
  localparam int ACC_RD  = 2;
  localparam int ACC_MEM = 3;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // Instruction format classes
  localparam insn_class_t CLASS_U       = 4'd0;
  localparam insn_class_t CLASS_J       = 4'd1;
  localparam insn_class_t CLASS_JALR    = 4'd2;
  localparam insn_class_t CLASS_I       = 4'd3;
  localparam insn_class_t CLASS_SHIFT   = 4'd4;
  localparam insn_class_t CLASS_B       = 4'd5;
  localparam insn_class_t CLASS_LOAD    = 4'd6;
  localparam insn_class_t CLASS_STORE   = 4'd7;
  localparam insn_class_t CLASS_R       = 4'd8;
  localparam insn_class_t CLASS_CSR     = 4'd9;
  localparam insn_class_t CLASS_CSR_IMM = 4'd10;
  localparam insn_class_t CLASS_FENCE   = 4'd11;
  localparam insn_class_t CLASS_SYS     = 4'd12;
  localparam insn_class_t CLASS_INVALID = 4'd15;

  // Mnemonic codes
  localparam op_t OP_LUI     = 6'd0;
  localparam op_t OP_AUIPC   = 6'd1;
  localparam op_t OP_JAL     = 6'd2;
  localparam op_t OP_JALR    = 6'd3;
  localparam op_t OP_BEQ     = 6'd4;
  localparam op_t OP_BNE     = 6'd5;
  localparam op_t OP_BLT     = 6'd6;
  localparam op_t OP_BGE     = 6'd7;
  localparam op_t OP_BLTU    = 6'd8;
  localparam op_t OP_BGEU    = 6'd9;
  localparam op_t OP_LB      = 6'd10;
  localparam op_t OP_LH      = 6'd11;
  localparam op_t OP_LW      = 6'd12;
  localparam op_t OP_LBU     = 6'd13;
  localparam op_t OP_LHU     = 6'd14;
  localparam op_t OP_SB      = 6'd15;
  localparam op_t OP_SH      = 6'd16;
  localparam op_t OP_SW      = 6'd17;
  localparam op_t OP_ADDI    = 6'd18;
  localparam op_t OP_SLTI    = 6'd19;
  localparam op_t OP_SLTIU   = 6'd20;
  localparam op_t OP_XORI    = 6'd21;
  localparam op_t OP_ORI     = 6'd22;
  localparam op_t OP_ANDI    = 6'd23;
  localparam op_t OP_SLLI    = 6'd24;
  localparam op_t OP_SRLI    = 6'd25;
  localparam op_t OP_SRAI    = 6'd26;
  localparam op_t OP_ADD     = 6'd27;
  localparam op_t OP_SUB     = 6'd28;
  localparam op_t OP_SLL     = 6'd29;
  localparam op_t OP_SLT     = 6'd30;
  localparam op_t OP_SLTU    = 6'd31;
  localparam op_t OP_XOR     = 6'd32;
  localparam op_t OP_SRL     = 6'd33;
  localparam op_t OP_SRA     = 6'd34;
  localparam op_t OP_OR      = 6'd35;
  localparam op_t OP_AND     = 6'd36;
  localparam op_t OP_FENCE   = 6'd37;
  localparam op_t OP_FENCE_I = 6'd38;
  localparam op_t OP_CSRRW   = 6'd39;
  localparam op_t OP_CSRRS   = 6'd40;
  localparam op_t OP_CSRRC   = 6'd41;
  localparam op_t OP_CSRRWI  = 6'd42;
  localparam op_t OP_CSRRSI  = 6'd43;
  localparam op_t OP_CSRRCI  = 6'd44;
  localparam op_t OP_ECALL   = 6'd45;
  localparam op_t OP_EBREAK  = 6'd46;
  localparam op_t OP_MRET    = 6'd47;
  localparam op_t OP_DRET    = 6'd48;
  localparam op_t OP_WFI     = 6'd49;
  localparam op_t OP_INVALID = 6'd63;

endpackage

// File: hdl/trace_record_reg.sv
// #########################################################################
// Trace record register. One record per valid strobe, no back-pressure,
// so each record is held only until the next strobe overwrites it.
// #########################################################################
`timescale 1ns/1ps

module trace_record_reg (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid,
  input  trace_pkg::word_t        insn,
  input  trace_pkg::word_t        pc,
  input  trace_pkg::word_t        imm,
  input  trace_pkg::word_t        target,
  input  trace_pkg::word_t        mem_addr,
  input  trace_pkg::word_t        mem_data,
  input  trace_pkg::word_t        rs1_data,
  input  trace_pkg::word_t        rs2_data,
  input  trace_pkg::word_t        rd_data,
  input  trace_pkg::reg_addr_t    rs1,
  input  trace_pkg::reg_addr_t    rs2,
  input  trace_pkg::reg_addr_t    rd,
  input  trace_pkg::insn_class_t  insn_class,
  input  trace_pkg::op_t          op,
  input  trace_pkg::access_mask_t access,
  output logic                    rec_valid,
  output trace_pkg::cycle_t       rec_cycle,
  output trace_pkg::word_t        rec_insn,
  output trace_pkg::word_t        rec_pc,
  output trace_pkg::word_t        rec_imm,
  output trace_pkg::word_t        rec_target,
  output trace_pkg::word_t        rec_mem_addr,
  output trace_pkg::word_t        rec_mem_data,
  output trace_pkg::word_t        rec_rs1_data,
  output trace_pkg::word_t        rec_rs2_data,
  output trace_pkg::word_t        rec_rd_data,
  output trace_pkg::reg_addr_t    rec_rs1,
  output trace_pkg::reg_addr_t    rec_rs2,
  output trace_pkg::reg_addr_t    rec_rd,
  output trace_pkg::insn_class_t  rec_insn_class,
  output trace_pkg::op_t          rec_op,
  output trace_pkg::access_mask_t rec_access
);

  trace_pkg::cycle_t cycle_q;

  // Free-running cycle stamp and the record strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q   <= '0;
      rec_valid <= 1'b0;
    end else begin
      cycle_q   <= cycle_q + 32'd1;
      rec_valid <= valid;
    end
  end

  // Stamp is the count before this edge's increment
  always_ff @(posedge clk_i) begin
    if (valid) begin
      rec_cycle      <= cycle_q;
      rec_insn       <= insn;
      rec_pc         <= pc;
      rec_imm        <= imm;
      rec_target     <= target;
      rec_mem_addr   <= mem_addr;
      rec_mem_data   <= mem_data;
      rec_rs1_data   <= rs1_data;
      rec_rs2_data   <= rs2_data;
      rec_rd_data    <= rd_data;
      rec_rs1        <= rs1;
      rec_rs2        <= rs2;
      rec_rd         <= rd;
      rec_insn_class <= insn_class;
      rec_op         <= op;
      rec_access     <= access;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the trace recorder testbench with Verilator.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_rvfi_trace -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// File: include/tb_vectors.svh
// ##########################################################################
// Stimulus and expected decode for the trace recorder testbench. Register
// and memory data are not listed here; the testbench derives them per entry.
// ##########################################################################
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  trace_pkg::word_t        insn;
  trace_pkg::word_t        pc;
  trace_pkg::word_t        pc_next;
  trace_pkg::mem_mask_t    rmask;
  trace_pkg::mem_mask_t    wmask;
  trace_pkg::insn_class_t  exp_class;
  trace_pkg::op_t          exp_op;
  trace_pkg::access_mask_t exp_access;
  trace_pkg::word_t        exp_imm;
  trace_pkg::word_t        exp_target;
} vector_t;

localparam int NUM_VECTORS = 29;

// Columns: insn, pc, pc_next, rmask, wmask, class, op, access (mem rd rs2 rs1), imm, target
localparam vector_t VECTORS [NUM_VECTORS] = '{
  '{32'h123450B7, 32'h0000_00F8, 32'h0000_00FC, 4'h0, 4'h0,
    trace_pkg::CLASS_U, trace_pkg::OP_LUI, 4'b0100, 32'h0001_2345, 32'h0},
  '{32'hFFFFF117, 32'h0000_00FC, 32'h0000_0100, 4'h0, 4'h0,
    trace_pkg::CLASS_U, trace_pkg::OP_AUIPC, 4'b0100, 32'h000F_FFFF, 32'h0},
  '{32'h008000EF, 32'h0000_0100, 32'h0000_0108, 4'h0, 4'h0,
    trace_pkg::CLASS_J, trace_pkg::OP_JAL, 4'b0100, 32'h0, 32'h0000_0108},
  '{32'hFFC280E7, 32'h0000_0108, 32'h0000_2000, 4'h0, 4'h0,
    trace_pkg::CLASS_JALR, trace_pkg::OP_JALR, 4'b0101, 32'hFFFF_FFFC, 32'h0000_2000},
  // Forward taken branch, then a backward one not taken
  '{32'h00208863, 32'h0000_0200, 32'h0000_0210, 4'h0, 4'h0,
    trace_pkg::CLASS_B, trace_pkg::OP_BEQ, 4'b0011, 32'h0000_0010, 32'h0000_0210},
  '{32'hFE209CE3, 32'h0000_0300, 32'h0000_0304, 4'h0, 4'h0,
    trace_pkg::CLASS_B, trace_pkg::OP_BNE, 4'b0011, 32'hFFFF_FFF8, 32'h0000_02F8},
  '{32'hFFC12183, 32'h0000_0400, 32'h0000_0404, 4'hF, 4'h0,
    trace_pkg::CLASS_LOAD, trace_pkg::OP_LW, 4'b1101, 32'hFFFF_FFFC, 32'h0},
  '{32'h00814203, 32'h0000_0404, 32'h0000_0408, 4'h1, 4'h0,
    trace_pkg::CLASS_LOAD, trace_pkg::OP_LBU, 4'b1101, 32'h0000_0008, 32'h0},
  '{32'h00013183, 32'h0000_0408, 32'h0000_040C, 4'h0, 4'h0,
    trace_pkg::CLASS_INVALID, trace_pkg::OP_INVALID, 4'b0000, 32'h0, 32'h0},
  '{32'hFE512A23, 32'h0000_040C, 32'h0000_0410, 4'h0, 4'hF,
    trace_pkg::CLASS_STORE, trace_pkg::OP_SW, 4'b1011, 32'hFFFF_FFF4, 32'h0},
  '{32'h006101A3, 32'h0000_0410, 32'h0000_0414, 4'h0, 4'h1,
    trace_pkg::CLASS_STORE, trace_pkg::OP_SB, 4'b1011, 32'h0000_0003, 32'h0},
  '{32'h00513023, 32'h0000_0414, 32'h0000_0418, 4'h0, 4'h0,
    trace_pkg::CLASS_INVALID, trace_pkg::OP_INVALID, 4'b0000, 32'h0, 32'h0},
  '{32'hFFF00093, 32'h0000_0418, 32'h0000_041C, 4'h0, 4'h0,
    trace_pkg::CLASS_I, trace_pkg::OP_ADDI, 4'b0101, 32'hFFFF_FFFF, 32'h0},
  '{32'h0F03F393, 32'h0000_041C, 32'h0000_0420, 4'h0, 4'h0,
    trace_pkg::CLASS_I, trace_pkg::OP_ANDI, 4'b0101, 32'h0000_00F0, 32'h0},
  '{32'h40545413, 32'h0000_0420, 32'h0000_0424, 4'h0, 4'h0,
    trace_pkg::CLASS_SHIFT, trace_pkg::OP_SRAI, 4'b0101, 32'h0000_0005, 32'h0},
  '{32'h01F49493, 32'h0000_0424, 32'h0000_0428, 4'h0, 4'h0,
    trace_pkg::CLASS_SHIFT, trace_pkg::OP_SLLI, 4'b0101, 32'h0000_001F, 32'h0},
  '{32'h402081B3, 32'h0000_0428, 32'h0000_042C, 4'h0, 4'h0,
    trace_pkg::CLASS_R, trace_pkg::OP_SUB, 4'b0111, 32'h0, 32'h0},
  '{32'h0062B233, 32'h0000_042C, 32'h0000_0430, 4'h0, 4'h0,
    trace_pkg::CLASS_R, trace_pkg::OP_SLTU, 4'b0111, 32'h0, 32'h0},
  '{32'h0FF0000F, 32'h0000_0430, 32'h0000_0434, 4'h0, 4'h0,
    trace_pkg::CLASS_FENCE, trace_pkg::OP_FENCE, 4'b0000, 32'h0000_00FF, 32'h0},
  '{32'h0000100F, 32'h0000_0434, 32'h0000_0438, 4'h0, 4'h0,
    trace_pkg::CLASS_FENCE, trace_pkg::OP_FENCE_I, 4'b0000, 32'h0, 32'h0},
  '{32'h300110F3, 32'h0000_0438, 32'h0000_043C, 4'h0, 4'h0,
    trace_pkg::CLASS_CSR, trace_pkg::OP_CSRRW, 4'b0101, 32'h0000_0300, 32'h0},
  '{32'h304262F3, 32'h0000_043C, 32'h0000_0440, 4'h0, 4'h0,
    trace_pkg::CLASS_CSR_IMM, trace_pkg::OP_CSRRSI, 4'b0100, 32'h0000_0304, 32'h0},
  '{32'h00000073, 32'h0000_0440, 32'h0000_0444, 4'h0, 4'h0,
    trace_pkg::CLASS_SYS, trace_pkg::OP_ECALL, 4'b0000, 32'h0, 32'h0},
  '{32'h00100073, 32'h0000_0444, 32'h0000_0448, 4'h0, 4'h0,
    trace_pkg::CLASS_SYS, trace_pkg::OP_EBREAK, 4'b0000, 32'h0, 32'h0},
  '{32'h30200073, 32'h0000_0448, 32'h0000_044C, 4'h0, 4'h0,
    trace_pkg::CLASS_SYS, trace_pkg::OP_MRET, 4'b0000, 32'h0, 32'h0},
  '{32'h7B200073, 32'h0000_044C, 32'h0000_0450, 4'h0, 4'h0,
    trace_pkg::CLASS_SYS, trace_pkg::OP_DRET, 4'b0000, 32'h0, 32'h0},
  '{32'h10500073, 32'h0000_0450, 32'h0000_0454, 4'h0, 4'h0,
    trace_pkg::CLASS_SYS, trace_pkg::OP_WFI, 4'b0000, 32'h0, 32'h0},
  // Compressed word, then an unknown major opcode
  '{32'h00000505, 32'h0000_0454, 32'h0000_0456, 4'h0, 4'h0,
    trace_pkg::CLASS_INVALID, trace_pkg::OP_INVALID, 4'b0000, 32'h0, 32'h0},
  '{32'h0000007F, 32'h0000_0456, 32'h0000_045A, 4'h0, 4'h0,
    trace_pkg::CLASS_INVALID, trace_pkg::OP_INVALID, 4'b0000, 32'h0, 32'h0}
};

`endif

// File: verification/tb_rvfi_trace.sv
// ##########################################################################
// Testbench for the RVFI trace recorder. Applies the vector table with
// random idle gaps of 0 to 2 cycles and checks every record at the negedge.
// ##########################################################################
`timescale 1ns/1ps

module tb_rvfi_trace;

  `include "tb_vectors.svh"

  localparam int RESET_CYCLES = 4;
  localparam int TIMEOUT      = 20;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic rvfi_valid;
  trace_pkg::word_t     rvfi_insn, rvfi_pc_rdata, rvfi_pc_wdata;
  trace_pkg::reg_addr_t rvfi_rs1_addr, rvfi_rs2_addr, rvfi_rd_addr;
  trace_pkg::word_t     rvfi_rs1_rdata, rvfi_rs2_rdata, rvfi_rd_wdata;
  trace_pkg::word_t     rvfi_mem_addr, rvfi_mem_rdata, rvfi_mem_wdata;
  trace_pkg::mem_mask_t rvfi_mem_rmask, rvfi_mem_wmask;

  logic rec_valid;
  trace_pkg::cycle_t       rec_cycle;
  trace_pkg::word_t        rec_insn, rec_pc, rec_imm, rec_target;
  trace_pkg::word_t        rec_mem_addr, rec_mem_data;
  trace_pkg::word_t        rec_rs1_data, rec_rs2_data, rec_rd_data;
  trace_pkg::reg_addr_t    rec_rs1, rec_rs2, rec_rd;
  trace_pkg::insn_class_t  rec_insn_class;
  trace_pkg::op_t          rec_op;
  trace_pkg::access_mask_t rec_access;

  integer seed = 32'h27b6;
  int     edges = 0;
  int     drive_edge [NUM_VECTORS];
  int     rec_idx;

  rvfi_trace_top dut_i (.*);

  always #2 clk_i = ~clk_i;

  // Counts rising edges, read as the count before the current edge
  always @(posedge clk_i) begin
    edges <= edges + 1;
  end

  // Register and memory data, tagged per field and unique per entry
  function automatic trace_pkg::word_t field_data(input logic [3:0] tag, input int idx);
    return {tag, 20'h0, idx[7:0]};
  endfunction

  task automatic abort_run(input string msg);
    $display("** FAIL **");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_word(input trace_pkg::word_t got, input trace_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("FAIL %0t: record %0d %s is %h, expected %h", $time, rec_idx, what, got, exp);
      abort_run("Record field mismatch");
    end
  endtask

  task automatic check_reg_addr(input trace_pkg::reg_addr_t got,
                                input trace_pkg::reg_addr_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: record %0d %s is %0d, expected %0d", $time, rec_idx, what, got, exp);
      abort_run("Register address mismatch");
    end
  endtask

  task automatic check_cycle(input trace_pkg::cycle_t got, input trace_pkg::cycle_t exp,
                             input string what);
    if (got !== exp) begin
      $display("FAIL %0t: record %0d %s is %0d, expected %0d", $time, rec_idx, what, got, exp);
      abort_run("Cycle mismatch");
    end
  endtask

  task automatic check_class(input trace_pkg::insn_class_t got,
                             input trace_pkg::insn_class_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: record %0d class is %0d, expected %0d", $time, rec_idx, got, exp);
      abort_run("Class mismatch");
    end
  endtask

  task automatic check_op(input trace_pkg::op_t got, input trace_pkg::op_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: record %0d op is %0d, expected %0d", $time, rec_idx, got, exp);
      abort_run("Mnemonic mismatch");
    end
  endtask

  task automatic check_access(input trace_pkg::access_mask_t got,
                              input trace_pkg::access_mask_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: record %0d access is %b, expected %b", $time, rec_idx, got, exp);
      abort_run("Access mask mismatch");
    end
  endtask

  task automatic drive_entry(input int idx);
    vector_t v;
    v = VECTORS[idx];
    rvfi_valid     <= 1'b1;
    rvfi_insn      <= v.insn;
    rvfi_pc_rdata  <= v.pc;
    rvfi_pc_wdata  <= v.pc_next;
    rvfi_rs1_addr  <= v.insn[19:15];
    rvfi_rs2_addr  <= v.insn[24:20];
    rvfi_rd_addr   <= v.insn[11:7];
    rvfi_rs1_rdata <= field_data(4'hA, idx);
    rvfi_rs2_rdata <= field_data(4'hB, idx);
    rvfi_rd_wdata  <= field_data(4'hC, idx);
    rvfi_mem_addr  <= field_data(4'h8, idx);
    rvfi_mem_rmask <= v.rmask;
    rvfi_mem_wmask <= v.wmask;
    rvfi_mem_rdata <= field_data(4'hD, idx);
    rvfi_mem_wdata <= field_data(4'hE, idx);
  endtask

  // Sample once per negedge until rec_valid is seen
  task automatic wait_record();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!rec_valid) begin
      if (waited == TIMEOUT) begin
        abort_run("Timed out waiting for rec_valid");
      end
      waited++;
      @(negedge clk_i);
    end
  endtask

  initial begin
    int gap;
    rst_ni = 1'b0;
    rvfi_valid = 1'b0;
    rvfi_insn = '0;
    rvfi_pc_rdata = '0;
    rvfi_pc_wdata = '0;
    rvfi_rs1_addr = '0;
    rvfi_rs2_addr = '0;
    rvfi_rd_addr = '0;
    rvfi_rs1_rdata = '0;
    rvfi_rs2_rdata = '0;
    rvfi_rd_wdata = '0;
    rvfi_mem_addr = '0;
    rvfi_mem_rmask = '0;
    rvfi_mem_wmask = '0;
    rvfi_mem_rdata = '0;
    rvfi_mem_wdata = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      @(posedge clk_i);
      drive_edge[i] = edges;
      drive_entry(i);
      gap = ($random(seed) & 32'h7fff_ffff) % 3;
      repeat (gap) begin
        @(posedge clk_i);
        rvfi_valid <= 1'b0;
      end
    end
    @(posedge clk_i);
    rvfi_valid <= 1'b0;
  end

  initial begin
    vector_t          v;
    trace_pkg::word_t exp_mem;
    trace_pkg::cycle_t prev_cycle;
    prev_cycle = '0;
    for (int k = 0; k < NUM_VECTORS; k++) begin
      rec_idx = k;
      wait_record();
      v = VECTORS[k];
      // Strobe driven at edge E is sampled at E+1, record shows after E+2
      check_cycle(trace_pkg::cycle_t'(edges), trace_pkg::cycle_t'(drive_edge[k] + 2),
                  "rec_valid edge");
      if (k == 0) begin
        // Counter leaves zero at the first edge after reset release
        check_cycle(rec_cycle, trace_pkg::cycle_t'(drive_edge[0] + 1 - RESET_CYCLES),
                    "first stamp");
      end else begin
        check_cycle(rec_cycle - prev_cycle,
                    trace_pkg::cycle_t'(drive_edge[k] - drive_edge[k - 1]), "cycle step");
      end
      prev_cycle = rec_cycle;
      check_class(rec_insn_class, v.exp_class);
      check_op(rec_op, v.exp_op);
      check_access(rec_access, v.exp_access);
      check_word(rec_insn, v.insn, "insn");
      check_word(rec_pc, v.pc, "pc");
      check_word(rec_imm, v.exp_imm, "imm");
      check_word(rec_target, v.exp_target, "target");
      check_reg_addr(rec_rs1, v.insn[19:15], "rs1");
      check_reg_addr(rec_rs2, v.insn[24:20], "rs2");
      check_reg_addr(rec_rd, v.insn[11:7], "rd");
      check_word(rec_rs1_data, field_data(4'hA, k), "rs1 data");
      check_word(rec_rs2_data, field_data(4'hB, k), "rs2 data");
      check_word(rec_rd_data, field_data(4'hC, k), "rd data");
      check_word(rec_mem_addr, field_data(4'h8, k), "mem addr");
      exp_mem = (v.rmask != '0) ? field_data(4'hD, k) : field_data(4'hE, k);
      check_word(rec_mem_data, exp_mem, "mem data");
    end
    // No stray pulse once the table is done
    repeat (4) begin
      @(negedge clk_i);
      if (rec_valid) begin
        abort_run("rec_valid pulsed after the last record");
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
hdl/trace_pkg.sv
hdl/insn_decoder.sv
hdl/operand_calc.sv
hdl/trace_record_reg.sv
hdl/rvfi_trace_top.sv
verification/tb_rvfi_trace.sv
